/* logic/lsu_pkg.sv */
package lsu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int csr_num_w   = 14;
    localparam int sram_addr_w = 10;
    localparam int strb_w      = xlen / 8;

    // access size encoding, shared by loads and stores.
    localparam logic [1:0] size_none = 2'd0;
    localparam logic [1:0] size_byte = 2'd1;
    localparam logic [1:0] size_half = 2'd2;
    localparam logic [1:0] size_word = 2'd3;

    ////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic intr;
        logic sys;
        logic brk;
        logic adef;
        logic adem;
        logic ine;
        logic ertn;
    } exc_flags_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [1:0]            load_size;
        logic [1:0]            store_size;
        logic                  load_signed;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        exc_flags_t            exc;
        logic                  op_csr;
        logic [csr_num_w-1:0]  csr_num;
        logic [xlen-1:0]       csr_wmask;
        logic [reg_addr_w-1:0] rj;
    } ex_req_t;

    // adem is filled in by the issue stage.
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       alu_result;
        logic [1:0]            load_size;
        logic                  load_signed;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        exc_flags_t            exc;
        logic                  op_csr;
        logic [csr_num_w-1:0]  csr_num;
        logic [xlen-1:0]       csr_wmask;
        logic [reg_addr_w-1:0] rj;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       result;
        logic                  gr_we;
        exc_flags_t            exc;
        logic                  op_csr;
        logic [csr_num_w-1:0]  csr_num;
        logic [xlen-1:0]       csr_wmask;
        logic [reg_addr_w-1:0] rj;
    } wb_req_t;

    // dest reads zero while the stage is empty.
    typedef struct packed {
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       result;
        logic                  op_csr;
    } fwd_t;

    typedef struct packed {
        logic [csr_num_w-1:0]  csr_num;
        logic [xlen-1:0]       wmask;
        logic [reg_addr_w-1:0] rj;
    } csr_req_t;

endpackage

/* logic/ex_mem_issue.sv */
`timescale 1ns/100ps

module ex_mem_issue (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush,
    input  logic                           in_valid,
    input  lsu_pkg::ex_req_t               in_req,
    output logic                           allow_in,
    input  logic                           mem_allow_in,
    input  logic                           mem_ex,
    input  logic                           wb_ex,
    output logic                           out_valid,
    output lsu_pkg::mem_req_t              out_req,
    output logic                           sram_en,
    output logic [lsu_pkg::strb_w-1:0]     sram_we,
    output logic [lsu_pkg::sram_addr_w-1:0] sram_addr,
    output logic [lsu_pkg::xlen-1:0]       sram_wdata
);
    import lsu_pkg::*;

    logic              valid_q;
    ex_req_t           req_q;
    logic [1:0]        acc_size;
    logic [1:0]        byte_off;
    logic              misaligned;
    logic [strb_w-1:0] store_strb;
    logic              write_ok;

    assign allow_in  = ~valid_q | mem_allow_in;
    assign out_valid = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (allow_in) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allow_in) begin
            req_q <= in_req;
        end
    end

    ////////////////////////////////////////
    // alignment check
    ////////////////////////////////////////

    assign byte_off = req_q.alu_result[1:0];
    assign acc_size = (req_q.load_size != size_none) ? req_q.load_size : req_q.store_size;

    always_comb begin
        case (acc_size)
            size_half: misaligned = byte_off[0];
            size_word: misaligned = |byte_off;
            default:   misaligned = 1'b0;
        endcase
    end

    always_comb begin
        out_req.pc          = req_q.pc;
        out_req.alu_result  = req_q.alu_result;
        out_req.load_size   = req_q.load_size;
        out_req.load_signed = req_q.load_signed;
        out_req.dest        = req_q.dest;
        out_req.gr_we       = req_q.gr_we;
        out_req.exc         = req_q.exc;
        out_req.exc.adem    = req_q.exc.adem | misaligned;
        out_req.op_csr      = req_q.op_csr;
        out_req.csr_num     = req_q.csr_num;
        out_req.csr_wmask   = req_q.csr_wmask;
        out_req.rj          = req_q.rj;
    end

    ////////////////////////////////////////
    // sram request
    ////////////////////////////////////////

    always_comb begin
        case (req_q.store_size)
            size_byte: store_strb = 4'b0001 << byte_off;
            size_half: store_strb = 4'b0011 << byte_off;
            size_word: store_strb = 4'b1111;
            default:   store_strb = 4'b0000;
        endcase
    end

    // an older faulting item in MEM or WB kills the store.
    assign write_ok = valid_q && (req_q.store_size != size_none) && !misaligned
                      && !(|req_q.exc) && !mem_ex && !wb_ex;

    assign sram_en    = valid_q && mem_allow_in && (acc_size != size_none);
    assign sram_we    = write_ok ? store_strb : '0;
    assign sram_addr  = req_q.alu_result[sram_addr_w+1:2];
    assign sram_wdata = req_q.store_data << {byte_off, 3'b000};

    // the sram drops strobes that arrive without an enabled request.
    a_write_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        (|sram_we) |-> sram_en
    );

endmodule

/* logic/data_sram.sv */
`timescale 1ns/100ps

module data_sram (
    input  logic                            clk,
    input  logic                            en,
    input  logic [lsu_pkg::strb_w-1:0]      we,
    input  logic [lsu_pkg::sram_addr_w-1:0] addr,
    input  logic [lsu_pkg::xlen-1:0]        wdata,
    output logic [lsu_pkg::xlen-1:0]        rdata
);
    import lsu_pkg::*;

    logic [xlen-1:0] mem_q [2**sram_addr_w];

    // byte lanes are written independently.
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < strb_w; i++) begin
                if (we[i]) begin
                    mem_q[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read-before-write, so a store returns the old word.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem_q[addr];
        end
    end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    in_valid,
    input  lsu_pkg::mem_req_t       in_req,
    output logic                    allow_in,
    input  logic                    wb_allow_in,
    input  logic [lsu_pkg::xlen-1:0] rdata,
    output logic                    out_valid,
    output lsu_pkg::wb_req_t        out_req,
    output logic                    mem_ex,
    output lsu_pkg::fwd_t           fwd
);
    import lsu_pkg::*;

    logic            valid_q;
    mem_req_t        req_q;
    logic            is_load;
    logic [1:0]      byte_off;
    logic [7:0]      load_byte;
    logic [15:0]     load_half;
    logic [xlen-1:0] load_value;
    logic [xlen-1:0] final_result;

    assign allow_in  = ~valid_q | wb_allow_in;
    assign out_valid = valid_q;
    assign mem_ex    = valid_q && (|req_q.exc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (allow_in) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allow_in) begin
            req_q <= in_req;
        end
    end

    ////////////////////////////////////////
    // load alignment
    ////////////////////////////////////////

    assign is_load  = req_q.load_size != size_none;
    assign byte_off = req_q.alu_result[1:0];

    always_comb begin
        case (byte_off)
            2'b00:   load_byte = rdata[7:0];
            2'b01:   load_byte = rdata[15:8];
            2'b10:   load_byte = rdata[23:16];
            default: load_byte = rdata[31:24];
        endcase
    end

    // halves are only legal at offset 0 or 2.
    assign load_half = byte_off[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (req_q.load_size)
            size_byte: load_value = {{24{req_q.load_signed & load_byte[7]}}, load_byte};
            size_half: load_value = {{16{req_q.load_signed & load_half[15]}}, load_half};
            default:   load_value = rdata;
        endcase
    end

    assign final_result = is_load ? load_value : req_q.alu_result;

    always_comb begin
        out_req.pc        = req_q.pc;
        out_req.dest      = req_q.dest;
        out_req.result    = final_result;
        out_req.gr_we     = req_q.gr_we;
        out_req.exc       = req_q.exc;
        out_req.op_csr    = req_q.op_csr;
        out_req.csr_num   = req_q.csr_num;
        out_req.csr_wmask = req_q.csr_wmask;
        out_req.rj        = req_q.rj;
    end

    assign fwd.dest   = valid_q ? req_q.dest : '0;
    assign fwd.result = final_result;
    assign fwd.op_csr = valid_q & req_q.op_csr;

    // the sram must have answered the read issued one cycle earlier.
    a_rdata_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_q && is_load && !mem_ex) |-> !$isunknown(rdata)
    );

endmodule

/* logic/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  lsu_pkg::wb_req_t              in_req,
    output logic                          allow_in,
    output logic                          wb_ex,
    output logic                          flush,
    output logic                          commit_valid,
    output logic [lsu_pkg::xlen-1:0]       commit_pc,
    output logic                          commit_we,
    output logic [lsu_pkg::reg_addr_w-1:0] commit_dest,
    output logic [lsu_pkg::xlen-1:0]       commit_data,
    output logic                          csr_valid,
    output lsu_pkg::csr_req_t             csr_req,
    output lsu_pkg::fwd_t                 fwd
);
    import lsu_pkg::*;

    logic    valid_q;
    wb_req_t req_q;
    logic    has_exc;

    assign allow_in = 1'b1;

    // an item leaving MEM during a flush is younger and must not land here.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid && !wb_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= in_req;
        end
    end

    ////////////////////////////////////////
    // commit
    ////////////////////////////////////////

    assign has_exc = |req_q.exc;
    assign wb_ex   = valid_q && has_exc;
    assign flush   = wb_ex;

    assign commit_valid = valid_q;
    assign commit_pc    = req_q.pc;
    assign commit_we    = valid_q && req_q.gr_we && !has_exc && (req_q.dest != '0);
    assign commit_dest  = req_q.dest;
    assign commit_data  = req_q.result;

    assign csr_valid       = valid_q && req_q.op_csr && !has_exc;
    assign csr_req.csr_num = req_q.csr_num;
    assign csr_req.wmask   = req_q.csr_wmask;
    assign csr_req.rj      = req_q.rj;

    assign fwd.dest   = valid_q ? req_q.dest : '0;
    assign fwd.result = req_q.result;
    assign fwd.op_csr = valid_q & req_q.op_csr;

    // a register write never carries unknown data into the register file.
    a_commit_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_we |-> !$isunknown(commit_data)
    );

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/100ps

module lsu_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    input  lsu_pkg::ex_req_t              ex_req,
    output logic                          ex_allow_in,
    output lsu_pkg::fwd_t                 mem_fwd,
    output lsu_pkg::fwd_t                 wb_fwd,
    output logic                          commit_valid,
    output logic [lsu_pkg::xlen-1:0]       commit_pc,
    output logic                          commit_we,
    output logic [lsu_pkg::reg_addr_w-1:0] commit_dest,
    output logic [lsu_pkg::xlen-1:0]       commit_data,
    output logic                          csr_valid,
    output lsu_pkg::csr_req_t             csr_req,
    output logic                          flush
);
    import lsu_pkg::*;

    logic                   ex_to_mem_valid;
    mem_req_t               mem_req;
    logic                   mem_allow_in;
    logic                   mem_ex;
    logic                   mem_to_wb_valid;
    wb_req_t                wb_req;
    logic                   wb_allow_in;
    logic                   wb_ex;
    logic                   sram_en;
    logic [strb_w-1:0]      sram_we;
    logic [sram_addr_w-1:0] sram_addr;
    logic [xlen-1:0]        sram_wdata;
    logic [xlen-1:0]        sram_rdata;

    ex_mem_issue ex_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .in_valid     (ex_valid),
        .in_req       (ex_req),
        .allow_in     (ex_allow_in),
        .mem_allow_in (mem_allow_in),
        .mem_ex       (mem_ex),
        .wb_ex        (wb_ex),
        .out_valid    (ex_to_mem_valid),
        .out_req      (mem_req),
        .sram_en      (sram_en),
        .sram_we      (sram_we),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata)
    );

    data_sram sram_i (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    mem_stage mem_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (ex_to_mem_valid),
        .in_req      (mem_req),
        .allow_in    (mem_allow_in),
        .wb_allow_in (wb_allow_in),
        .rdata       (sram_rdata),
        .out_valid   (mem_to_wb_valid),
        .out_req     (wb_req),
        .mem_ex      (mem_ex),
        .fwd         (mem_fwd)
    );

    wb_stage wb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (mem_to_wb_valid),
        .in_req       (wb_req),
        .allow_in     (wb_allow_in),
        .wb_ex        (wb_ex),
        .flush        (flush),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_we    (commit_we),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data),
        .csr_valid    (csr_valid),
        .csr_req      (csr_req),
        .fwd          (wb_fwd)
    );

endmodule

/* verification/lsu_tb.sv */
`timescale 1ns/100ps

module lsu_tb;
    import lsu_pkg::*;

    typedef struct packed {
        logic [31:0] due;
        logic [31:0] pc;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
        logic        flush;
        logic        csr_valid;
        csr_req_t    csr;
    } exp_commit_t;

    localparam int n_word        = 16;
    localparam int n_lane_words  = 2;
    localparam int n_partial     = 8;
    localparam int total_items   = 2 * n_word + 13 * n_lane_words + 4 * n_partial + 16 + 7;
    localparam int timeout_limit = total_items + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  ex_valid;
    ex_req_t               ex_req;
    logic                  ex_allow_in;
    fwd_t                  mem_fwd;
    fwd_t                  wb_fwd;
    logic                  commit_valid;
    logic [xlen-1:0]       commit_pc;
    logic                  commit_we;
    logic [reg_addr_w-1:0] commit_dest;
    logic [xlen-1:0]       commit_data;
    logic                  csr_valid;
    csr_req_t              csr_req;
    logic                  flush;

    logic [7:0]  shadow [4096];
    exp_commit_t exp_q [$];
    exp_commit_t cur;
    integer      seed = 32'h3b6d_60ee;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] next_pc;

    lsu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_req       (ex_req),
        .ex_allow_in  (ex_allow_in),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_we    (commit_we),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data),
        .csr_valid    (csr_valid),
        .csr_req      (csr_req),
        .flush        (flush)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    function automatic logic is_misaligned(input ex_req_t req);
        logic [1:0] size;
        size = (req.load_size != size_none) ? req.load_size : req.store_size;
        return (size == size_half && req.alu_result[0]) ||
               (size == size_word && req.alu_result[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] shadow_load(input logic [11:0] a, input logic [1:0] size,
                                                input logic sgn);
        case (size)
            size_byte: return {{24{sgn & shadow[a][7]}}, shadow[a]};
            size_half: return {{16{sgn & shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            default:   return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
        endcase
    endfunction

    function automatic ex_req_t store_req(input logic [31:0] addr, input logic [1:0] size,
                                          input logic [31:0] data);
        ex_req_t r;
        r            = '0;
        r.alu_result = addr;
        r.store_size = size;
        r.store_data = data;
        return r;
    endfunction

    function automatic ex_req_t load_req(input logic [31:0] addr, input logic [1:0] size,
                                         input logic sgn, input logic [4:0] dest);
        ex_req_t r;
        r             = '0;
        r.alu_result  = addr;
        r.load_size   = size;
        r.load_signed = sgn;
        r.dest        = dest;
        r.gr_we       = 1'b1;
        return r;
    endfunction

    function automatic ex_req_t alu_req(input logic [31:0] value, input logic [4:0] dest);
        ex_req_t r;
        r            = '0;
        r.alu_result = value;
        r.dest       = dest;
        r.gr_we      = 1'b1;
        return r;
    endfunction

    // items that a flush will cancel are driven but never expected.
    task automatic issue_item(input ex_req_t req, input logic dropped);
        exp_commit_t e;
        logic        exc;
        logic [11:0] a;
        int          nbytes;
        @(negedge clk);
        req.pc   = next_pc;
        next_pc  = next_pc + 4;
        ex_valid = 1'b1;
        ex_req   = req;
        check_value("ex_allow_in", ex_allow_in, 1'b1);
        if (!dropped) begin
            exc         = (|req.exc) || is_misaligned(req);
            a           = req.alu_result[11:0];
            e           = '0;
            e.due       = cycles + 3;
            e.pc        = req.pc;
            e.we        = req.gr_we && !exc && (req.dest != 5'd0);
            e.dest      = req.dest;
            e.flush     = exc;
            e.csr_valid = req.op_csr && !exc;
            e.csr       = '{csr_num: req.csr_num, wmask: req.csr_wmask, rj: req.rj};
            if (req.load_size != size_none) begin
                e.data = shadow_load(a, req.load_size, req.load_signed);
            end else begin
                e.data = req.alu_result;
            end
            if (!exc && req.store_size != size_none) begin
                nbytes = 1 << (req.store_size - 1);
                for (int i = 0; i < nbytes; i++) begin
                    shadow[a+i] = req.store_data[8*i +: 8];
                end
            end
            exp_q.push_back(e);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // commit monitor, one expected entry per committed item.
    always @(negedge clk) begin
        if (rst_n) begin
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a commit for pc %h arrived with no item expected", commit_pc);
                end else begin
                    cur = exp_q.pop_front();
                    check_value("commit cycle", cycles, cur.due);
                    check_value("commit_pc", commit_pc, cur.pc);
                    check_value("commit_we", commit_we, cur.we);
                    check_value("flush", flush, cur.flush);
                    check_value("csr_valid", csr_valid, cur.csr_valid);
                    if (cur.we) begin
                        check_value("commit_dest", commit_dest, cur.dest);
                        check_value("commit_data", commit_data, cur.data);
                    end
                    if (cur.csr_valid) begin
                        check_value("csr_req.csr_num", csr_req.csr_num, cur.csr.csr_num);
                        check_value("csr_req.wmask", csr_req.wmask, cur.csr.wmask);
                        check_value("csr_req.rj", csr_req.rj, cur.csr.rj);
                    end
                end
            end else begin
                check_value("commit_we while idle", commit_we, 1'b0);
                check_value("flush while idle", flush, 1'b0);
                check_value("csr_valid while idle", csr_valid, 1'b0);
                if (exp_q.size() != 0 && exp_q[0].due <= cycles) begin
                    errors++;
                    $display("the item with pc %h never committed", exp_q[0].pc);
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_word_store_load();
        logic [31:0] addrs [n_word];
        for (int i = 0; i < n_word; i++) begin
            addrs[i] = ($random(seed) & 32'h3ff) << 2;
            issue_item(store_req(addrs[i], size_word, $random(seed)), 1'b0);
        end
        for (int i = 0; i < n_word; i++) begin
            issue_item(load_req(addrs[i], size_word, 1'b0, 5'(i % 31 + 1)), 1'b0);
        end
        drain();
    endtask

    task automatic test_lane_loads();
        logic [31:0] base;
        logic [31:0] data;
        for (int w = 0; w < n_lane_words; w++) begin
            base = 32'h400 + 4 * w;
            data = (w == 0) ? 32'h817e_c33c : $random(seed);
            issue_item(store_req(base, size_word, data), 1'b0);
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < 4; off++) begin
                    issue_item(load_req(base + off, size_byte, s[0], 5'(off + 1)), 1'b0);
                end
                for (int off = 0; off < 4; off += 2) begin
                    issue_item(load_req(base + off, size_half, s[0], 5'(off + 8)), 1'b0);
                end
            end
        end
        drain();
    endtask

    task automatic test_partial_stores();
        logic [31:0] base;
        logic [31:0] boff;
        logic [31:0] hoff;
        for (int i = 0; i < n_partial; i++) begin
            base = 32'h500 + 4 * i;
            boff = $random(seed) & 3;
            hoff = ($random(seed) & 1) << 1;
            issue_item(store_req(base, size_word, $random(seed)), 1'b0);
            issue_item(store_req(base + boff, size_byte, $random(seed)), 1'b0);
            issue_item(store_req(base + hoff, size_half, $random(seed)), 1'b0);
            issue_item(load_req(base, size_word, 1'b0, 5'(i + 10)), 1'b0);
        end
        drain();
    endtask

    // each faulting item is followed by two younger items that the flush cancels.
    task automatic test_misaligned();
        issue_item(store_req(32'h600, size_word, 32'h1122_3344), 1'b0);
        issue_item(store_req(32'h604, size_word, 32'h5566_7788), 1'b0);
        issue_item(load_req(32'h601, size_half, 1'b1, 5'd5), 1'b0);
        issue_item(store_req(32'h600, size_word, 32'hdead_beef), 1'b1);
        issue_item(store_req(32'h604, size_word, 32'hfeed_f00d), 1'b1);
        idle_cycle();
        issue_item(load_req(32'h602, size_word, 1'b0, 5'd6), 1'b0);
        issue_item(alu_req(32'h1234, 5'd7), 1'b1);
        issue_item(load_req(32'h604, size_word, 1'b0, 5'd8), 1'b1);
        idle_cycle();
        issue_item(store_req(32'h606, size_word, 32'h0bad_cafe), 1'b0);
        issue_item(alu_req(32'h99, 5'd9), 1'b1);
        issue_item(alu_req(32'h9a, 5'd9), 1'b1);
        idle_cycle();
        issue_item(store_req(32'h603, size_half, 32'h5a5a), 1'b0);
        issue_item(alu_req(32'h9b, 5'd9), 1'b1);
        issue_item(alu_req(32'h9c, 5'd9), 1'b1);
        idle_cycle();
        issue_item(load_req(32'h600, size_word, 1'b0, 5'd10), 1'b0);
        issue_item(load_req(32'h604, size_word, 1'b0, 5'd11), 1'b0);
        drain();
    endtask

    task automatic test_non_memory();
        ex_req_t r;
        issue_item(alu_req(32'hcafe_0001, 5'd12), 1'b0);
        idle_cycle();
        idle_cycle();
        check_value("mem_fwd.dest", mem_fwd.dest, 5'd12);
        check_value("mem_fwd.result", mem_fwd.result, 32'hcafe_0001);
        check_value("wb_fwd.dest while empty", wb_fwd.dest, 5'd0);
        idle_cycle();
        check_value("wb_fwd.dest", wb_fwd.dest, 5'd12);
        check_value("wb_fwd.result", wb_fwd.result, 32'hcafe_0001);
        check_value("mem_fwd.dest while empty", mem_fwd.dest, 5'd0);
        r           = alu_req(32'h55, 5'd13);
        r.op_csr    = 1'b1;
        r.csr_num   = 14'h0c0;
        r.csr_wmask = 32'h0000_ff00;
        r.rj        = 5'd4;
        issue_item(r, 1'b0);
        idle_cycle();
        idle_cycle();
        check_value("mem_fwd.op_csr", mem_fwd.op_csr, 1'b1);
        check_value("wb_fwd.op_csr while empty", wb_fwd.op_csr, 1'b0);
        idle_cycle();
        check_value("wb_fwd.op_csr", wb_fwd.op_csr, 1'b1);
        check_value("mem_fwd.op_csr while empty", mem_fwd.op_csr, 1'b0);
        issue_item(alu_req(32'h77, 5'd0), 1'b0);
        for (int i = 0; i < 4; i++) begin
            issue_item(alu_req($random(seed), 5'(20 + i)), 1'b0);
        end
        drain();
    endtask

    initial begin
        rst_n    = 1'b0;
        ex_valid = 1'b0;
        ex_req   = '0;
        next_pc  = 32'h1c00_0000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("commit_valid after reset", commit_valid, 1'b0);
        check_value("mem_fwd.dest after reset", mem_fwd.dest, 5'd0);
        check_value("wb_fwd.dest after reset", wb_fwd.dest, 5'd0);
        test_word_store_load();
        test_lane_loads();
        test_partial_stores();
        test_misaligned();
        test_non_memory();
        drain();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/lsu_pkg.sv
logic/ex_mem_issue.sv
logic/data_sram.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/lsu_top.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - logic/lsu_pkg.sv
      - logic/ex_mem_issue.sv
      - logic/data_sram.sv
      - logic/mem_stage.sv
      - logic/wb_stage.sv
      - logic/lsu_top.sv
  - target: test
    files:
      - verification/lsu_tb.sv
